// ==== filelist.f ====
source/core_pkg.sv
source/unified_mem.sv
source/mem_arbiter.sv
source/regfile.sv
source/alu.sv
source/idu.sv
source/lsu_wb.sv
source/ifu.sv
source/rv_top.sv
dv/tb_top.sv

// ==== Makefile ====
# Verilator build and run for the RV32I core testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -j 0
PASS_MSG  ?= ** PASS **

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only when the simulation output holds the pass message
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/tb_top.sv ====
`timescale 1ns/100ps
module tb_top import core_pkg::*; ();

  localparam int MEM_WORDS  = 1024;
  localparam int AW         = $clog2(MEM_WORDS);
  localparam int DATA_BASE  = 'h400;
  localparam int DATA_WORDS = 16;
  localparam int RES_BASE   = 'h600;
  localparam int RES_WORDS  = 64;
  localparam int UNTOUCHED  = DATA_BASE + 4 * (DATA_WORDS - 1); // never loaded or stored
  localparam int MAX_STEPS  = 20000;

  logic        clk = 1'b0;
  logic        rst_n, start, host_req, host_we;
  logic [31:0] host_addr, host_wdata, host_rdata;
  logic        host_rsp, halted;

  logic [31:0] prog [$];
  logic [31:0] image [MEM_WORDS];     // memory contents at start
  logic [31:0] model_mem [MEM_WORDS]; // memory after the reference run
  logic [31:0] ref_pc;
  int          seed = 37146;
  int          slot, ls_slot, zero_slot;
  int          errors, req_count, rsp_count, conc_reads, limit_cycles;
  logic        started = 1'b0;
  logic        halt_seen = 1'b0;

  rv_top #(.RESET_PC(32'h0), .MEM_WORDS(MEM_WORDS)) rv_top_i (
    .clk, .rst_n, .start, .host_req, .host_we, .host_addr, .host_wdata,
    .host_rsp, .host_rdata, .halted
  );

  always #4 clk = ~clk;

  // instruction encoders
  function automatic logic [31:0] r_type(input int f3, input int f7, input int rd,
                                         input int rs1, input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
  endfunction

  function automatic logic [31:0] i_type(input opcode_e op, input int f3, input int rd,
                                         input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic logic [31:0] s_type(input int rs1, input int rs2, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'd2, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] b_type(input int f3, input int rs1, input int rs2,
                                         input int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] u_type(input opcode_e op, input int rd, input int imm);
    return {imm[19:0], rd[4:0], op};
  endfunction

  function automatic logic [31:0] j_type(input int rd, input int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
  endfunction

  // x2 holds the result area base
  task automatic store_result(input int rs);
    prog.push_back(s_type(2, rs, slot * 4));
    slot++;
  endtask

  task automatic build_program();
    int r_f3 [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
    int r_f7 [10] = '{0, 32, 0, 0, 0, 0, 0, 32, 0, 0};
    int i_f3 [9]  = '{0, 2, 3, 4, 6, 7, 1, 5, 5};
    int i_imm [9] = '{-5, -5, -5, 'h7f3, 'h155, -256, 7, 13, 'h40d};
    int br_f3 [6] = '{0, 1, 4, 5, 6, 7};
    int loop_at;
    slot = 0;
    prog.push_back(i_type(OPC_OP_IMM, 0, 1, 0, DATA_BASE));
    prog.push_back(i_type(OPC_OP_IMM, 0, 2, 0, RES_BASE));
    prog.push_back(i_type(OPC_LOAD, 2, 3, 1, 0));
    prog.push_back(i_type(OPC_LOAD, 2, 4, 1, 4));
    prog.push_back(u_type(OPC_LUI, 5, 'hfffff)); // negative operand
    prog.push_back(i_type(OPC_LOAD, 2, 6, 1, 8));
    prog.push_back(i_type(OPC_OP_IMM, 7, 6, 6, 31)); // small positive
    for (int p = 0; p < 2; p++) begin
      for (int k = 0; k < 10; k++) begin
        prog.push_back(r_type(r_f3[k], r_f7[k], 7, 3 + 2 * p, 4 + 2 * p));
        store_result(7);
      end
      for (int k = 0; k < 9; k++) begin
        prog.push_back(i_type(OPC_OP_IMM, i_f3[k], 7, 3 + 2 * p, i_imm[k]));
        store_result(7);
      end
    end
    ls_slot = slot;
    store_result(3);
    prog.push_back(i_type(OPC_LOAD, 2, 8, 2, ls_slot * 4));
    store_result(8);
    zero_slot = slot;
    store_result(0);
    // x9 counts taken branches, x10 runs 2 down to -2
    prog.push_back(i_type(OPC_OP_IMM, 0, 9, 0, 0));
    prog.push_back(i_type(OPC_OP_IMM, 0, 10, 0, 2));
    prog.push_back(i_type(OPC_OP_IMM, 0, 13, 0, 0));
    prog.push_back(i_type(OPC_OP_IMM, 0, 14, 0, -3));
    loop_at = prog.size();
    for (int k = 0; k < 6; k++) begin
      prog.push_back(b_type(br_f3[k], 10, 13, 8)); // taken lands on the increment
      prog.push_back(j_type(0, 8));
      prog.push_back(i_type(OPC_OP_IMM, 0, 9, 9, 1));
    end
    prog.push_back(i_type(OPC_OP_IMM, 0, 10, 10, -1));
    prog.push_back(b_type(1, 10, 14, (loop_at - prog.size()) * 4));
    store_result(9);
    prog.push_back(i_type(OPC_OP_IMM, 0, 15, 0, 'h5a5)); // post-loop marker
    store_result(15);
    store_result(10);
    prog.push_back(u_type(OPC_LUI, 16, 'h12345));
    store_result(16);
    prog.push_back(u_type(OPC_AUIPC, 17, 'h10));
    store_result(17);
    prog.push_back(j_type(18, 8));
    prog.push_back(i_type(OPC_OP_IMM, 0, 9, 9, 77)); // skipped by jal
    store_result(18);
    prog.push_back(u_type(OPC_AUIPC, 19, 0));
    prog.push_back(i_type(OPC_OP_IMM, 0, 19, 19, 16));
    prog.push_back(i_type(OPC_JALR, 0, 20, 19, 1)); // odd target, bit 0 dropped
    prog.push_back(i_type(OPC_OP_IMM, 0, 9, 9, 200)); // skipped by jalr
    store_result(20);
    store_result(19);
    store_result(9);
    prog.push_back(i_type(OPC_SYSTEM, 0, 0, 0, 1)); // ebreak
  endtask

  function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: r = (a < b) ? 32'd1 : 32'd0;
      3'd4: r = a ^ b;
      3'd5: begin
        if (alt) r = $signed(a) >>> b[4:0];
        else     r = a >> b[4:0];
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  // instruction set model over model_mem, returns the executed count
  function automatic int ref_run();
    logic [31:0] xr [32];
    logic [31:0] pc, npc, ins, a, b, ea, res;
    logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic        wr, stop;
    int          steps;
    for (int i = 0; i < 32; i++) xr[i] = '0;
    pc    = '0;
    stop  = 1'b0;
    steps = 0;
    while (!stop && steps < MAX_STEPS) begin
      ins   = model_mem[pc[AW+1:2]];
      rd    = ins[11:7];
      f3    = ins[14:12];
      a     = xr[ins[19:15]];
      b     = xr[ins[24:20]];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      imm_u = {ins[31:12], 12'h000};
      imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      npc   = pc + 32'd4;
      wr    = 1'b1;
      res   = '0;
      steps++;
      case (ins[6:0])
        OPC_LUI:   res = imm_u;
        OPC_AUIPC: res = pc + imm_u;
        OPC_JAL: begin
          res = npc;
          npc = pc + imm_j;
        end
        OPC_JALR: begin
          res    = npc;
          npc    = a + imm_i;
          npc[0] = 1'b0;
        end
        OPC_BRANCH: begin
          wr = 1'b0;
          if (branch_taken(f3, a, b)) npc = pc + imm_b;
        end
        OPC_LOAD: begin
          ea  = a + imm_i;
          res = model_mem[ea[AW+1:2]];
        end
        OPC_STORE: begin
          wr = 1'b0;
          ea = a + imm_s;
          model_mem[ea[AW+1:2]] = b;
        end
        OPC_OP_IMM: res = alu_model(f3, (f3 == 3'd5) && ins[30], a, imm_i);
        OPC_OP:     res = alu_model(f3, ins[30], a, b);
        OPC_SYSTEM: begin
          wr   = 1'b0;
          stop = 1'b1; // ebreak, pc stays on it
        end
        default: wr = 1'b0;
      endcase
      if (wr && rd != 5'd0) xr[rd] = res;
      if (!stop) pc = npc;
    end
    ref_pc = pc;
    return steps;
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Fail at time %0t: %s, got %08h expected %08h", $time, what, got, exp);
      $display("** FAIL **");
      $fatal(1, "check failed");
    end
  endtask

  task automatic mem_access(input logic we, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    @(posedge clk);
    host_req   <= 1'b1;
    host_we    <= we;
    host_addr  <= addr;
    host_wdata <= wdata;
    req_count++;
    @(posedge clk);
    host_req <= 1'b0;
    @(negedge clk);
    while (!host_rsp) @(negedge clk);
    rdata = host_rdata;
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    mem_access(1'b1, addr, data, unused);
  endtask

  task automatic read_word(input logic [31:0] addr, output logic [31:0] data);
    mem_access(1'b0, addr, '0, data);
  endtask

  task automatic compare_results(input string tag);
    logic [31:0] v;
    for (int i = 0; i < RES_WORDS; i++) begin
      read_word(RES_BASE + 4 * i, v);
      check(v, model_mem[(RES_BASE >> 2) + i], $sformatf("%s, result slot %0d", tag, i));
    end
  endtask

  // halted and host response monitor
  always @(negedge clk) begin
    if (rst_n) begin
      if (halt_seen) check({31'b0, halted}, 32'd1, "halted dropped after ebreak");
      if (!started) check({31'b0, halted}, 32'd0, "halted high before start");
      if (halted) halt_seen = 1'b1;
      if (host_rsp) rsp_count++;
    end
  end

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: the run did not complete within %0d cycles", limit_cycles);
    $display("** FAIL **");
    $fatal(1, "watchdog expired");
  end

  initial begin
    logic [31:0] v;
    int          ref_steps;
    int          n_writes;
    rst_n      <= 1'b0;
    start      <= 1'b0;
    host_req   <= 1'b0;
    host_we    <= 1'b0;
    host_addr  <= '0;
    host_wdata <= '0;
    build_program();
    for (int i = 0; i < MEM_WORDS; i++) image[i] = '0;
    foreach (prog[i]) image[i] = prog[i];
    for (int i = 0; i < DATA_WORDS; i++) image[(DATA_BASE >> 2) + i] = $random(seed);
    for (int i = 0; i < RES_WORDS; i++) begin
      image[(RES_BASE >> 2) + i] = 32'hc0de_0000 ^ (RES_BASE + 4 * i);
    end
    model_mem    = image;
    ref_steps    = ref_run();
    n_writes     = prog.size() + DATA_WORDS + RES_WORDS;
    limit_cycles = ref_steps * 40 + (n_writes + 3 * RES_WORDS) * 8 + 100;

    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    foreach (prog[i]) write_word(4 * i, image[i]);
    for (int i = 0; i < DATA_WORDS; i++) begin
      write_word(DATA_BASE + 4 * i, image[(DATA_BASE >> 2) + i]);
    end
    for (int i = 0; i < RES_WORDS; i++) begin
      write_word(RES_BASE + 4 * i, image[(RES_BASE >> 2) + i]);
    end

    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start   <= 1'b0;
    started = 1'b1;

    // host traffic competes with the core until it halts
    fork
      wait (halted);
      while (!halted) begin
        read_word(UNTOUCHED, v);
        check(v, image[UNTOUCHED >> 2], "host read during the run");
        conc_reads++;
        repeat (3) @(posedge clk);
      end
    join

    check(rv_top_i.pc, ref_pc, "final pc");
    compare_results("after halt");
    read_word(RES_BASE + 4 * (ls_slot + 1), v);
    check(v, image[DATA_BASE >> 2], "load of a stored word");
    read_word(RES_BASE + 4 * zero_slot, v);
    check(v, 32'd0, "store from x0");
    compare_results("repeated read");
    @(posedge clk);
    check((conc_reads > 0) ? 32'd1 : 32'd0, 32'd1, "host reads overlapping the run");
    check(rsp_count, req_count, "host responses against host requests");

    if (errors == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("** FAIL **");
      $fatal(1, "%0d checks failed", errors);
    end
  end

endmodule

// ==== source/rv_top.sv ====
`timescale 1ns/100ps
module rv_top import core_pkg::*; #(
  parameter logic [31:0] RESET_PC = 32'h0,
  parameter int MEM_WORDS = 1024
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start,
  input  logic        host_req,
  input  logic        host_we,
  input  logic [31:0] host_addr,
  input  logic [31:0] host_wdata,
  output logic        host_rsp,
  output logic [31:0] host_rdata,
  output logic        halted
);

  localparam int AW = $clog2(MEM_WORDS);

  logic [XLEN-1:0] pc, insn, imm, alu_result, rs1_data, rs2_data;
  logic [4:0]      rs1, rs2, rd;
  alu_op_e         alu_op;
  src_a_e          src_a;
  src_b_e          src_b;
  br_op_e          br_op;
  wb_sel_e         wb_sel;
  logic            reg_we, is_mem, mem_we, halt_insn, alu_zero, exec;
  logic            if_req, if_rsp, ls_req, ls_we, ls_rsp, ls_done;
  logic [XLEN-1:0] if_rdata, ls_addr, ls_wdata, ls_rdata;
  logic            rf_we;
  logic [4:0]      rf_rd;
  logic [XLEN-1:0] rf_wd;
  logic            mem_en, mem_wen;
  logic [AW-1:0]   mem_addr;
  logic [XLEN-1:0] mem_wdata, mem_rdata;

  ifu #(.RESET_PC(RESET_PC)) ifu_i (
    .clk, .rst_n, .start, .halt_insn, .ls_done, .alu_zero, .alu_result, .imm,
    .insn_rdata(if_rdata), .is_mem, .br_op, .if_rsp, .if_req, .pc, .insn,
    .exec, .halted
  );

  idu idu_i (
    .insn, .rs1, .rs2, .rd, .imm, .alu_op, .src_a, .src_b, .br_op, .wb_sel,
    .reg_we, .is_mem, .mem_we, .halt_insn
  );

  regfile regfile_i (
    .clk, .rs1, .rs2, .rd(rf_rd), .we(rf_we), .wd(rf_wd), .rs1_data, .rs2_data
  );

  alu alu_i (
    .op(alu_op), .src_a, .src_b, .rs1_data, .rs2_data, .pc, .imm,
    .result(alu_result), .zero(alu_zero)
  );

  lsu_wb lsu_wb_i (
    .clk, .rst_n, .exec, .is_mem, .mem_we, .reg_we, .wb_sel, .alu_result,
    .rs2_data, .pc, .rd, .ls_rsp, .ls_rdata, .ls_req, .ls_we, .ls_addr,
    .ls_wdata, .ls_done, .rf_we, .rf_rd, .rf_wd
  );

  mem_arbiter #(.MEM_WORDS(MEM_WORDS)) mem_arbiter_i (
    .clk, .rst_n,
    .host_req, .host_we, .host_addr, .host_wdata, .host_rsp, .host_rdata,
    .ls_req, .ls_we, .ls_addr, .ls_wdata, .ls_rsp, .ls_rdata,
    .if_req, .if_we(1'b0), .if_addr(pc), .if_wdata('0), .if_rsp, .if_rdata,
    .mem_en, .mem_we(mem_wen), .mem_addr, .mem_wdata, .mem_rdata
  );

  unified_mem #(.MEM_WORDS(MEM_WORDS)) unified_mem_i (
    .clk, .en(mem_en), .we(mem_wen), .addr(mem_addr), .wdata(mem_wdata),
    .rdata(mem_rdata)
  );

endmodule

// ==== source/ifu.sv ====
`timescale 1ns/100ps
module ifu import core_pkg::*; #(
  parameter logic [31:0] RESET_PC = 32'h0
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start,
  input  logic        halt_insn,
  input  logic        ls_done,
  input  logic        alu_zero,
  input  logic [31:0] alu_result,
  input  logic [31:0] imm,
  input  logic [31:0] insn_rdata,
  input  logic        is_mem,
  input  br_op_e      br_op,
  input  logic        if_rsp,
  output logic        if_req,
  output logic [31:0] pc,
  output logic [31:0] insn,
  output logic        exec,
  output logic        halted
);

  seq_state_e state;
  logic       taken;
  logic [31:0] next_pc;

  // slt/sltu leave the compare outcome in bit 0
  always_comb begin
    case (br_op)
      BR_BEQ:                taken = alu_zero;
      BR_BNE:                taken = !alu_zero;
      BR_BLT, BR_BLTU:       taken = alu_result[0];
      BR_BGE, BR_BGEU:       taken = !alu_result[0];
      BR_JAL:                taken = 1'b1;
      default:               taken = 1'b0; // none, jalr
    endcase
  end

  always_comb begin
    if (br_op == BR_JALR) next_pc = {alu_result[31:1], 1'b0};
    else if (taken)       next_pc = pc + imm;
    else                  next_pc = pc + INSN_BYTES;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= S_IDLE;
      pc    <= RESET_PC;
    end else begin
      case (state)
        S_IDLE:      if (start) state <= S_FETCH;
        S_FETCH:     state <= S_WAIT_INSN; // req goes out this cycle
        S_WAIT_INSN: if (if_rsp) state <= S_EXEC;
        S_EXEC: begin
          if (halt_insn) begin
            state <= S_HALT;
          end else if (is_mem) begin
            pc    <= pc + INSN_BYTES;
            state <= S_WAIT_MEM;
          end else begin
            pc    <= next_pc;
            state <= S_FETCH;
          end
        end
        S_WAIT_MEM:  if (ls_done) state <= S_FETCH;
        default:     state <= S_HALT; // stays halted
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_WAIT_INSN && if_rsp) insn <= insn_rdata;
  end

  assign if_req = (state == S_FETCH);
  assign exec   = (state == S_EXEC);
  assign halted = (state == S_HALT);

endmodule

// ==== source/lsu_wb.sv ====
`timescale 1ns/100ps
module lsu_wb import core_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        exec,
  input  logic        is_mem,
  input  logic        mem_we,
  input  logic        reg_we,
  input  wb_sel_e     wb_sel,
  input  logic [31:0] alu_result,
  input  logic [31:0] rs2_data,
  input  logic [31:0] pc,
  input  logic [4:0]  rd,
  input  logic        ls_rsp,
  input  logic [31:0] ls_rdata,
  output logic        ls_req,
  output logic        ls_we,
  output logic [31:0] ls_addr,
  output logic [31:0] ls_wdata,
  output logic        ls_done,
  output logic        rf_we,
  output logic [4:0]  rf_rd,
  output logic [31:0] rf_wd
);

  logic       load_pend; // a load is waiting for its data
  logic [4:0] rd_q;

  always_ff @(posedge clk) begin
    if (!rst_n)                      load_pend <= 1'b0;
    else if (ls_req)                 load_pend <= !mem_we && reg_we;
    else if (ls_rsp)                 load_pend <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (ls_req) rd_q <= rd;
  end

  assign ls_req   = exec && is_mem;
  assign ls_we    = mem_we;
  assign ls_addr  = alu_result;
  assign ls_wdata = rs2_data;
  assign ls_done  = ls_rsp;

  // exec-cycle writeback for non-memory ops, rsp-cycle for loads
  assign rf_we = (exec && !is_mem && reg_we) || (ls_rsp && load_pend);
  assign rf_rd = ls_rsp ? rd_q : rd;

  always_comb begin
    case (wb_sel)
      WB_PC4:  rf_wd = pc + INSN_BYTES;
      WB_LOAD: rf_wd = ls_rdata;
      default: rf_wd = alu_result;
    endcase
  end

endmodule

// ==== source/idu.sv ====
`timescale 1ns/100ps
module idu import core_pkg::*; (
  input  logic [31:0] insn,
  output logic [4:0]  rs1,
  output logic [4:0]  rs2,
  output logic [4:0]  rd,
  output logic [31:0] imm,
  output alu_op_e     alu_op,
  output src_a_e      src_a,
  output src_b_e      src_b,
  output br_op_e      br_op,
  output wb_sel_e     wb_sel,
  output logic        reg_we,
  output logic        is_mem,
  output logic        mem_we,
  output logic        halt_insn
);

  opcode_e     opcode;
  logic [2:0]  funct3;
  logic        alt; // funct7 bit 5
  logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode = opcode_e'(insn[6:0]);
  assign funct3 = insn[14:12];
  assign alt    = insn[30];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign rd     = insn[11:7];

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

  // shared by OP and OP-IMM, sub only exists in the register form
  function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic a,
                                          input logic is_reg);
    case (f3)
      3'b000:  return (a && is_reg) ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return a ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  always_comb begin
    imm       = imm_i;
    alu_op    = ALU_ADD;
    src_a     = SRC_A_REG;
    src_b     = SRC_B_IMM;
    br_op     = BR_NONE;
    wb_sel    = WB_ALU;
    reg_we    = 1'b0;
    is_mem    = 1'b0;
    mem_we    = 1'b0;
    halt_insn = 1'b0;
    case (opcode)
      OPC_LUI: begin
        imm = imm_u; alu_op = ALU_PASS_B; reg_we = 1'b1;
      end
      OPC_AUIPC: begin
        imm = imm_u; src_a = SRC_A_PC; reg_we = 1'b1;
      end
      OPC_JAL: begin
        imm = imm_j; br_op = BR_JAL; wb_sel = WB_PC4; reg_we = 1'b1;
      end
      OPC_JALR: begin
        br_op = BR_JALR; wb_sel = WB_PC4; reg_we = 1'b1;
      end
      OPC_BRANCH: begin
        imm   = imm_b;
        src_b = SRC_B_REG;
        case (funct3[2:1])
          2'b00:   alu_op = ALU_SUB;
          2'b10:   alu_op = ALU_SLT;
          default: alu_op = ALU_SLTU;
        endcase
        case (funct3)
          3'b000:  br_op = BR_BEQ;
          3'b001:  br_op = BR_BNE;
          3'b100:  br_op = BR_BLT;
          3'b101:  br_op = BR_BGE;
          3'b110:  br_op = BR_BLTU;
          3'b111:  br_op = BR_BGEU;
          default: br_op = BR_NONE;
        endcase
      end
      OPC_LOAD: begin
        is_mem = 1'b1; wb_sel = WB_LOAD; reg_we = 1'b1; // word only
      end
      OPC_STORE: begin
        imm = imm_s; is_mem = 1'b1; mem_we = 1'b1;
      end
      OPC_OP_IMM: begin
        alu_op = alu_from_f3(funct3, alt, 1'b0); reg_we = 1'b1;
      end
      OPC_OP: begin
        alu_op = alu_from_f3(funct3, alt, 1'b1); src_b = SRC_B_REG; reg_we = 1'b1;
      end
      OPC_SYSTEM: halt_insn = (insn == EBREAK_INSN);
      default: ; // nop
    endcase
  end

endmodule

// ==== source/alu.sv ====
`timescale 1ns/100ps
module alu import core_pkg::*; (
  input  alu_op_e         op,
  input  src_a_e          src_a,
  input  src_b_e          src_b,
  input  logic [XLEN-1:0] rs1_data,
  input  logic [XLEN-1:0] rs2_data,
  input  logic [XLEN-1:0] pc,
  input  logic [XLEN-1:0] imm,
  output logic [XLEN-1:0] result,
  output logic            zero
);

  logic [XLEN-1:0] a, b;
  logic [4:0]      shamt;

  assign a     = (src_a == SRC_A_PC)  ? pc  : rs1_data;
  assign b     = (src_b == SRC_B_IMM) ? imm : rs2_data;
  assign shamt = b[4:0];

  always_comb begin
    case (op)
      ALU_ADD:  result = a + b;
      ALU_SUB:  result = a - b;
      ALU_AND:  result = a & b;
      ALU_OR:   result = a | b;
      ALU_XOR:  result = a ^ b;
      ALU_SLL:  result = a << shamt;
      ALU_SRL:  result = a >> shamt;
      ALU_SRA:  result = $signed(a) >>> shamt;
      ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU: result = {31'b0, a < b};
      default:  result = b; // pass-b for lui
    endcase
  end

  assign zero = (result == '0);

endmodule

// ==== source/regfile.sv ====
`timescale 1ns/100ps
module regfile import core_pkg::*; (
  input  logic            clk,
  input  logic [4:0]      rs1,
  input  logic [4:0]      rs2,
  input  logic [4:0]      rd,
  input  logic            we,
  input  logic [XLEN-1:0] wd,
  output logic [XLEN-1:0] rs1_data,
  output logic [XLEN-1:0] rs2_data
);

  logic [XLEN-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (we && rd != 5'd0) regs[rd] <= wd;
  end

  // x0 is never written, mask it on read
  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// ==== source/mem_arbiter.sv ====
`timescale 1ns/100ps
module mem_arbiter import core_pkg::*; #(
  parameter int MEM_WORDS = 1024
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         host_req,
  input  logic                         host_we,
  input  logic [XLEN-1:0]              host_addr,
  input  logic [XLEN-1:0]              host_wdata,
  output logic                         host_rsp,
  output logic [XLEN-1:0]              host_rdata,
  input  logic                         ls_req,
  input  logic                         ls_we,
  input  logic [XLEN-1:0]              ls_addr,
  input  logic [XLEN-1:0]              ls_wdata,
  output logic                         ls_rsp,
  output logic [XLEN-1:0]              ls_rdata,
  input  logic                         if_req,
  input  logic                         if_we,
  input  logic [XLEN-1:0]              if_addr,
  input  logic [XLEN-1:0]              if_wdata,
  output logic                         if_rsp,
  output logic [XLEN-1:0]              if_rdata,
  output logic                         mem_en,
  output logic                         mem_we,
  output logic [$clog2(MEM_WORDS)-1:0] mem_addr,
  output logic [XLEN-1:0]              mem_wdata,
  input  logic [XLEN-1:0]              mem_rdata
);

  localparam int AW = $clog2(MEM_WORDS);

  // port index order is the priority order: host, ls, if
  logic [2:0]      req, pend, gnt, gnt_q;
  logic            req_we [3];
  logic [XLEN-1:0] req_addr [3];
  logic [XLEN-1:0] req_wdata [3];
  logic            hold_we [3];
  logic [XLEN-1:0] hold_addr [3];
  logic [XLEN-1:0] hold_wdata [3];
  logic [1:0]      sel;

  assign req       = {if_req, ls_req, host_req};
  assign req_we    = '{host_we, ls_we, if_we};
  assign req_addr  = '{host_addr, ls_addr, if_addr};
  assign req_wdata = '{host_wdata, ls_wdata, if_wdata};

  always_comb begin
    gnt = 3'b000;
    sel = 2'd0;
    if (pend[0]) begin
      gnt[0] = 1'b1;
    end else if (pend[1]) begin
      gnt[1] = 1'b1;
      sel    = 2'd1;
    end else if (pend[2]) begin
      gnt[2] = 1'b1;
      sel    = 2'd2;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pend  <= 3'b000;
      gnt_q <= 3'b000;
    end else begin
      pend  <= (pend & ~gnt) | req; // losers stay pending
      gnt_q <= gnt;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < 3; i++) begin
      if (req[i]) begin
        hold_we[i]    <= req_we[i];
        hold_addr[i]  <= req_addr[i];
        hold_wdata[i] <= req_wdata[i];
      end
    end
  end

  assign mem_en    = |pend;
  assign mem_we    = hold_we[sel];
  assign mem_addr  = hold_addr[sel][AW+1:2]; // byte to word index
  assign mem_wdata = hold_wdata[sel];

  // read data lands one cycle after the grant
  assign host_rsp   = gnt_q[0];
  assign ls_rsp     = gnt_q[1];
  assign if_rsp     = gnt_q[2];
  assign host_rdata = mem_rdata;
  assign ls_rdata   = mem_rdata;
  assign if_rdata   = mem_rdata;

endmodule

// ==== source/unified_mem.sv ====
`timescale 1ns/100ps
module unified_mem import core_pkg::*; #(
  parameter int MEM_WORDS = 1024
) (
  input  logic                         clk,
  input  logic                         en,
  input  logic                         we,
  input  logic [$clog2(MEM_WORDS)-1:0] addr,
  input  logic [XLEN-1:0]              wdata,
  output logic [XLEN-1:0]              rdata
);

  logic [XLEN-1:0] mem [MEM_WORDS];

  always_ff @(posedge clk) begin
    if (en) begin
      if (we) mem[addr] <= wdata;
      rdata <= mem[addr]; // old word on a write
    end
  end

endmodule

// ==== source/core_pkg.sv ====
package core_pkg;

  localparam int XLEN = 32;
  localparam logic [31:0] INSN_BYTES = 32'd4;
  localparam logic [31:0] EBREAK_INSN = 32'h0010_0073;

  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
    ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PASS_B
  } alu_op_e;

  // the six branches keep their funct3 code, the other kinds sit above
  typedef enum logic [3:0] {
    BR_BEQ  = 4'd0,
    BR_BNE  = 4'd1,
    BR_BLT  = 4'd4,
    BR_BGE  = 4'd5,
    BR_BLTU = 4'd6,
    BR_BGEU = 4'd7,
    BR_NONE = 4'd8,
    BR_JAL  = 4'd9,
    BR_JALR = 4'd10
  } br_op_e;

  typedef enum logic [2:0] {
    S_IDLE, S_FETCH, S_WAIT_INSN, S_EXEC, S_WAIT_MEM, S_HALT
  } seq_state_e;

  typedef enum logic {SRC_A_REG, SRC_A_PC} src_a_e;
  typedef enum logic {SRC_B_REG, SRC_B_IMM} src_b_e;
  typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_PC4} wb_sel_e;

endpackage
